// ==== Bender.yml ====
package:
  name: vec_add

sources:
  # RTL in compile order
  - files:
      - hw/vec_add_pkg.sv
      - hw/vec_add_mem_if.sv
      - hw/vec_add_lane_if.sv
      - hw/vec_add_wb_port.sv
      - hw/vec_add_fetch.sv
      - hw/vec_add_pack.sv
      - hw/vec_add_top.sv

  # Testbench and bound checker
  - target: test
    files:
      - test/vec_add_assertions.sv
      - test/tb_vec_add.sv

// ==== hw/vec_add_fetch.sv ====
`timescale 1ns/1ps

module vec_add_fetch #(
    parameter int ROW_WORDS = 8,
    parameter int S_DEPTH   = 64
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_start,
    input  vec_add_pkg::gf_byte_t i_s_start,
    output logic                  o_busy,
    vec_add_mem_if.engine_rd      mem,
    vec_add_lane_if.src           lane
);
    import vec_add_pkg::*;

    localparam int VW = (ROW_WORDS > 1) ? $clog2(ROW_WORDS) : 1;
    localparam int SW = (S_DEPTH > 1) ? $clog2(S_DEPTH) : 1;
    localparam int BW = (N_GF > 1) ? $clog2(N_GF) : 1;

    engine_state_t state;
    logic [BW-1:0] byte_cnt;
    logic [VW-1:0] word_cnt;
    logic [SW-1:0] s_idx;
    logic          word_end;
    logic          row_end;

    assign word_end = (byte_cnt == BW'(N_GF - 1));
    assign row_end  = word_end && (word_cnt == VW'(ROW_WORDS - 1));

    // --------------------------------------------------
    // Run sequencing
    // --------------------------------------------------

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= ST_IDLE;
            byte_cnt <= '0;
            word_cnt <= '0;
            s_idx    <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        state    <= ST_RUN;
                        byte_cnt <= '0;
                        word_cnt <= '0;
                        s_idx    <= i_s_start[SW-1:0];
                    end
                end
                ST_RUN: begin
                    // Depth is a power of two, so the index wraps by itself
                    s_idx <= s_idx + 1'b1;
                    if (word_end) begin
                        byte_cnt <= '0;
                        word_cnt <= word_cnt + 1'b1;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                    if (row_end) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // One read and one tagged byte per run cycle
    assign o_busy            = (state == ST_RUN);
    assign mem.vec_addr      = word_cnt;
    assign mem.s_addr        = s_idx;
    assign lane.valid        = o_busy;
    assign lane.first        = (byte_cnt == '0);
    assign lane.last_in_word = word_end;
    assign lane.word_idx     = word_cnt;
    assign lane.final_byte   = row_end;

endmodule

// ==== hw/vec_add_lane_if.sv ====
`timescale 1ns/1ps

interface vec_add_lane_if #(
    parameter int ROW_WORDS = 8
);
    localparam int VW = (ROW_WORDS > 1) ? $clog2(ROW_WORDS) : 1;

    // One byte read issued this cycle
    logic          valid;

    // Tags for that byte
    logic          first;
    logic          last_in_word;
    logic [VW-1:0] word_idx;
    // Last byte of the row
    logic          final_byte;

    modport src (output valid, output first, output last_in_word,
                 output word_idx, output final_byte);
    modport dst (input valid, input first, input last_in_word,
                 input word_idx, input final_byte);

endinterface

// ==== hw/vec_add_mem_if.sv ====
`timescale 1ns/1ps

interface vec_add_mem_if #(
    parameter int ROW_WORDS = 8,
    parameter int S_DEPTH   = 64
);
    import vec_add_pkg::*;

    localparam int VW = (ROW_WORDS > 1) ? $clog2(ROW_WORDS) : 1;
    localparam int SW = (S_DEPTH > 1) ? $clog2(S_DEPTH) : 1;

    // Engine read side, data returns one cycle after the address
    logic [VW-1:0] vec_addr;
    logic [SW-1:0] s_addr;
    gf_word_t      vec_data;
    gf_byte_t      s_data;

    // Result write side
    logic          res_we;
    logic [VW-1:0] res_addr;
    gf_word_t      res_data;

    modport engine_rd (output vec_addr, output s_addr);
    modport engine_wr (input vec_data, input s_data,
                       output res_we, output res_addr, output res_data);
    modport mem (input vec_addr, input s_addr, output vec_data, output s_data,
                 input res_we, input res_addr, input res_data);

endinterface

// ==== hw/vec_add_pack.sv ====
`timescale 1ns/1ps

module vec_add_pack #(
    parameter int ROW_WORDS = 8
) (
    input  logic             i_clk,
    input  logic             i_rst,
    output logic             o_row_done,
    vec_add_lane_if.dst      lane,
    vec_add_mem_if.engine_wr mem
);
    import vec_add_pkg::*;

    localparam int VW = (ROW_WORDS > 1) ? $clog2(ROW_WORDS) : 1;

    // Tags delayed to line up with the read data
    logic          valid_q;
    logic          first_q;
    logic          last_q;
    logic          final_q;
    logic [VW-1:0] widx_q;

    gf_word_t      s_word;
    gf_word_t      packed_word;

    // Earliest byte ends up in the top lane
    assign packed_word = {s_word[WB_DW-9:0], mem.s_data};

    // --------------------------------------------------
    // Tag alignment
    // --------------------------------------------------

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= lane.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        first_q <= lane.first;
        last_q  <= lane.last_in_word;
        final_q <= lane.final_byte;
        widx_q  <= lane.word_idx;
    end

    // --------------------------------------------------
    // Shift register and result write
    // --------------------------------------------------

    always_ff @(posedge i_clk) begin
        if (valid_q) begin
            if (first_q) begin
                s_word <= gf_word_t'(mem.s_data);
            end else begin
                s_word <= packed_word;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (valid_q && last_q) begin
            mem.res_data <= packed_word ^ mem.vec_data;
            mem.res_addr <= widx_q;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            mem.res_we <= 1'b0;
            o_row_done <= 1'b0;
        end else begin
            mem.res_we <= valid_q && last_q;
            o_row_done <= valid_q && last_q && final_q;
        end
    end

endmodule

// ==== hw/vec_add_pkg.sv ====
package vec_add_pkg;

    // --------------------------------------------------
    // Widths and data types
    // --------------------------------------------------

    // Bytes per packed word
    localparam int N_GF = 4;

    // Wishbone data and word-address widths
    localparam int WB_DW = N_GF * 8;
    localparam int WB_AW = 10;

    typedef logic [7:0]       gf_byte_t;
    typedef logic [WB_DW-1:0] gf_word_t;
    typedef logic [WB_AW-1:0] wb_addr_t;

    // --------------------------------------------------
    // Register map
    // --------------------------------------------------

    // Region select on address bits 9..8
    localparam logic [1:0] REG_REGION = 2'd0;
    localparam logic [1:0] VEC_REGION = 2'd1;
    localparam logic [1:0] S_REGION   = 2'd2;
    localparam logic [1:0] RES_REGION = 2'd3;

    // Control register offsets
    localparam logic [7:0] CTRL_OFS   = 8'd0;
    localparam logic [7:0] STATUS_OFS = 8'd1;
    localparam logic [7:0] SSTART_OFS = 8'd2;

    // STATUS bit positions
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

    // --------------------------------------------------
    // Engine sequencing
    // --------------------------------------------------

    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } engine_state_t;

endpackage

// ==== hw/vec_add_top.sv ====
`timescale 1ns/1ps

module vec_add_top #(
    parameter int ROW_WORDS = 8,
    parameter int S_DEPTH   = 64
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_we,
    input  vec_add_pkg::wb_addr_t i_wb_adr,
    input  vec_add_pkg::gf_word_t i_wb_dat,
    output vec_add_pkg::gf_word_t o_wb_dat,
    output logic                  o_wb_ack,
    output logic                  o_irq
);
    import vec_add_pkg::*;

    logic     start;
    logic     busy;
    logic     row_done;
    gf_byte_t s_start;

    vec_add_mem_if #(
        .ROW_WORDS (ROW_WORDS),
        .S_DEPTH   (S_DEPTH)
    ) mem_bus ();

    vec_add_lane_if #(
        .ROW_WORDS (ROW_WORDS)
    ) lane_bus ();

    // --------------------------------------------------
    // Host port, fetch stage, pack stage
    // --------------------------------------------------

    vec_add_wb_port #(
        .ROW_WORDS (ROW_WORDS),
        .S_DEPTH   (S_DEPTH)
    ) u_wb_port (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_wb_cyc   (i_wb_cyc),
        .i_wb_stb   (i_wb_stb),
        .i_wb_we    (i_wb_we),
        .i_wb_adr   (i_wb_adr),
        .i_wb_dat   (i_wb_dat),
        .o_wb_dat   (o_wb_dat),
        .o_wb_ack   (o_wb_ack),
        .i_busy     (busy),
        .i_row_done (row_done),
        .o_start    (start),
        .o_s_start  (s_start),
        .o_irq      (o_irq),
        .mem        (mem_bus.mem)
    );

    vec_add_fetch #(
        .ROW_WORDS (ROW_WORDS),
        .S_DEPTH   (S_DEPTH)
    ) u_fetch (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_start   (start),
        .i_s_start (s_start),
        .o_busy    (busy),
        .mem       (mem_bus.engine_rd),
        .lane      (lane_bus.src)
    );

    vec_add_pack #(
        .ROW_WORDS (ROW_WORDS)
    ) u_pack (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .o_row_done (row_done),
        .lane       (lane_bus.dst),
        .mem        (mem_bus.engine_wr)
    );

endmodule

// ==== hw/vec_add_wb_port.sv ====
`timescale 1ns/1ps

module vec_add_wb_port #(
    parameter int ROW_WORDS = 8,
    parameter int S_DEPTH   = 64
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_we,
    input  vec_add_pkg::wb_addr_t i_wb_adr,
    input  vec_add_pkg::gf_word_t i_wb_dat,
    output vec_add_pkg::gf_word_t o_wb_dat,
    output logic                  o_wb_ack,
    input  logic                  i_busy,
    input  logic                  i_row_done,
    output logic                  o_start,
    output vec_add_pkg::gf_byte_t o_s_start,
    output logic                  o_irq,
    vec_add_mem_if.mem            mem
);
    import vec_add_pkg::*;

    localparam int VW = (ROW_WORDS > 1) ? $clog2(ROW_WORDS) : 1;
    localparam int SW = (S_DEPTH > 1) ? $clog2(S_DEPTH) : 1;

    gf_word_t vec_mem [ROW_WORDS];
    gf_byte_t s_mem   [S_DEPTH];
    gf_word_t res_mem [ROW_WORDS];

    logic          ack_q;
    logic          done_q;
    gf_byte_t      s_start_q;

    logic [1:0]    region;
    logic [7:0]    ofs;
    logic [VW-1:0] row_idx;
    logic [SW-1:0] s_idx;
    logic          row_ok;
    logic          req;
    logic          wr;

    // --------------------------------------------------
    // Address decode and handshake
    // --------------------------------------------------

    assign region  = i_wb_adr[9:8];
    assign ofs     = i_wb_adr[7:0];
    assign row_idx = ofs[VW-1:0];
    assign s_idx   = ofs[SW-1:0];
    assign row_ok  = (ofs < ROW_WORDS);

    // New request, ack follows next cycle
    assign req = i_wb_cyc && i_wb_stb && !ack_q;
    // Writes commit in the ack cycle
    assign wr  = i_wb_cyc && i_wb_stb && ack_q && i_wb_we;

    assign o_wb_ack  = ack_q;
    assign o_start   = wr && (region == REG_REGION) && (ofs == CTRL_OFS)
                       && i_wb_dat[0] && !i_busy;
    assign o_s_start = s_start_q;
    assign o_irq     = i_row_done;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ack_q     <= 1'b0;
            done_q    <= 1'b0;
            s_start_q <= '0;
        end else begin
            ack_q <= req;
            if (o_start) begin
                done_q <= 1'b0;
            end else if (i_row_done) begin
                done_q <= 1'b1;
            end
            if (wr && (region == REG_REGION) && (ofs == SSTART_OFS)) begin
                s_start_q <= i_wb_dat[7:0];
            end
        end
    end

    // --------------------------------------------------
    // Host side of the banks
    // --------------------------------------------------

    // Bank contents frozen while the engine runs
    always_ff @(posedge i_clk) begin
        if (wr && !i_busy) begin
            if ((region == VEC_REGION) && row_ok) begin
                vec_mem[row_idx] <= i_wb_dat;
            end
            if (region == S_REGION) begin
                s_mem[s_idx] <= i_wb_dat[7:0];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (req) begin
            case (region)
                REG_REGION: begin
                    case (ofs)
                        STATUS_OFS: begin
                            o_wb_dat <= '0;
                            o_wb_dat[STATUS_BUSY_BIT] <= i_busy;
                            o_wb_dat[STATUS_DONE_BIT] <= done_q;
                        end
                        SSTART_OFS: o_wb_dat <= gf_word_t'(s_start_q);
                        default:    o_wb_dat <= '0;
                    endcase
                end
                VEC_REGION: o_wb_dat <= row_ok ? vec_mem[row_idx] : '0;
                S_REGION:   o_wb_dat <= gf_word_t'(s_mem[s_idx]);
                default:    o_wb_dat <= row_ok ? res_mem[row_idx] : '0;
            endcase
        end
    end

    // --------------------------------------------------
    // Engine side of the banks
    // --------------------------------------------------

    always_ff @(posedge i_clk) begin
        mem.vec_data <= vec_mem[mem.vec_addr];
        mem.s_data   <= s_mem[mem.s_addr];
        if (mem.res_we) begin
            res_mem[mem.res_addr] <= mem.res_data;
        end
    end

endmodule

// ==== sources.f ====
hw/vec_add_pkg.sv
hw/vec_add_mem_if.sv
hw/vec_add_lane_if.sv
hw/vec_add_wb_port.sv
hw/vec_add_fetch.sv
hw/vec_add_pack.sv
hw/vec_add_top.sv
test/vec_add_assertions.sv
test/tb_vec_add.sv

// ==== test/tb_vec_add.sv ====
`timescale 1ns/1ps

module tb_vec_add;
    import vec_add_pkg::*;

    localparam int ROW_WORDS       = 8;
    localparam int S_DEPTH         = 64;
    localparam int L               = ROW_WORDS * N_GF;
    localparam int N_RUNS          = 6;
    localparam int WATCHDOG_CYCLES = N_RUNS * (L + 200) + 2000;
    localparam int ACK_LIMIT       = 20;
    localparam int POLL_LIMIT      = 100;

    logic     i_clk;
    logic     i_rst;
    logic     i_wb_cyc;
    logic     i_wb_stb;
    logic     i_wb_we;
    wb_addr_t i_wb_adr;
    gf_word_t i_wb_dat;
    gf_word_t o_wb_dat;
    logic     o_wb_ack;
    logic     o_irq;

    // Host copy of what the banks should hold
    gf_word_t vec_model [ROW_WORDS];
    gf_byte_t s_model   [S_DEPTH];

    logic [31:0] lfsr_state;
    logic [31:0] rnd;
    gf_word_t    rd_data;
    int          errors;
    int          checks;
    int          irq_count;
    int          irq_before;
    int          start_idx;

    vec_add_top #(
        .ROW_WORDS (ROW_WORDS),
        .S_DEPTH   (S_DEPTH)
    ) uut (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack),
        .o_irq    (o_irq)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    always @(negedge i_clk) begin
        if (!i_rst && o_irq) begin
            irq_count++;
        end
    end

    // --------------------------------------------------
    // Random data and reference model
    // --------------------------------------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic rand_bits(input int nbits, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    // Lane 0 of each word holds the earliest s byte in its top bits
    function automatic gf_word_t ref_result(input int w, input int start);
        gf_word_t packed_s;
        int       idx;
        packed_s = '0;
        for (int b = 0; b < N_GF; b++) begin
            idx = (start + w * N_GF + b) % S_DEPTH;
            packed_s[(N_GF - 1 - b) * 8 +: 8] = s_model[idx];
        end
        return vec_model[w] ^ packed_s;
    endfunction

    function automatic wb_addr_t make_addr(input logic [1:0] region, input int ofs);
        return {region, ofs[7:0]};
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // --------------------------------------------------
    // Wishbone master
    // --------------------------------------------------

    task automatic wb_access(input logic we, input wb_addr_t adr, input gf_word_t dat,
                             output gf_word_t rdata);
        int waited;
        waited = 0;
        @(posedge i_clk);
        i_wb_cyc <= 1'b1;
        i_wb_stb <= 1'b1;
        i_wb_we  <= we;
        i_wb_adr <= adr;
        i_wb_dat <= dat;
        do begin
            @(negedge i_clk);
            waited++;
        end while (!o_wb_ack && waited < ACK_LIMIT);
        if (!o_wb_ack) begin
            errors++;
            $display("ERROR at %0t: slave never acknowledged address %h", $time, adr);
        end
        rdata = o_wb_dat;
        @(posedge i_clk);
        i_wb_cyc <= 1'b0;
        i_wb_stb <= 1'b0;
        i_wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input gf_word_t dat);
        gf_word_t unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output gf_word_t dat);
        wb_access(1'b0, adr, '0, dat);
    endtask

    // --------------------------------------------------
    // Test steps
    // --------------------------------------------------

    // Upper bits of each s write carry junk that the bank drops
    task automatic load_banks();
        logic [31:0] val;
        for (int w = 0; w < ROW_WORDS; w++) begin
            rand_bits(32, val);
            vec_model[w] = val;
            wb_write(make_addr(VEC_REGION, w), val);
        end
        for (int i = 0; i < S_DEPTH; i++) begin
            rand_bits(32, val);
            s_model[i] = val[7:0];
            wb_write(make_addr(S_REGION, i), val);
        end
    endtask

    task automatic readback_banks();
        gf_word_t val;
        for (int w = 0; w < ROW_WORDS; w++) begin
            wb_read(make_addr(VEC_REGION, w), val);
            check_value(val, vec_model[w], $sformatf("vector word %0d", w));
        end
        for (int i = 0; i < S_DEPTH; i++) begin
            wb_read(make_addr(S_REGION, i), val);
            check_value(val, {24'h0, s_model[i]}, $sformatf("s entry %0d", i));
        end
    endtask

    task automatic start_run(input int start);
        wb_write(make_addr(REG_REGION, SSTART_OFS), start);
        irq_before = irq_count;
        wb_write(make_addr(REG_REGION, CTRL_OFS), 32'h1);
    endtask

    task automatic wait_done();
        gf_word_t status;
        int       polls;
        logic     finished;
        polls    = 0;
        finished = 1'b0;
        while (!finished && polls < POLL_LIMIT) begin
            wb_read(make_addr(REG_REGION, STATUS_OFS), status);
            finished = status[STATUS_DONE_BIT] && !status[STATUS_BUSY_BIT];
            polls++;
        end
        if (!finished) begin
            errors++;
            $display("ERROR at %0t: engine never finished", $time);
        end
    endtask

    task automatic finish_run(input int start);
        gf_word_t val;
        wait_done();
        check_value(irq_count - irq_before, 1, "irq pulses in run");
        wb_read(make_addr(REG_REGION, STATUS_OFS), val);
        check_value(val, 32'h2, "STATUS after run");
        for (int w = 0; w < ROW_WORDS; w++) begin
            wb_read(make_addr(RES_REGION, w), val);
            check_value(val, ref_result(w, start), $sformatf("result word %0d", w));
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        i_rst      = 1'b1;
        i_wb_cyc   = 1'b0;
        i_wb_stb   = 1'b0;
        i_wb_we    = 1'b0;
        i_wb_adr   = '0;
        i_wb_dat   = '0;
        lfsr_state = 32'hf805;
        errors     = 0;
        checks     = 0;
        irq_count  = 0;
        irq_before = 0;
        repeat (8) @(posedge i_clk);
        i_rst <= 1'b0;

        wb_read(make_addr(REG_REGION, STATUS_OFS), rd_data);
        check_value(rd_data, 32'h0, "STATUS after reset");
        wb_write(make_addr(REG_REGION, SSTART_OFS), 32'hABCD_12C5);
        wb_read(make_addr(REG_REGION, SSTART_OFS), rd_data);
        check_value(rd_data, 32'hC5, "SSTART readback");

        load_banks();
        readback_banks();

        start_run(0);
        finish_run(0);

        // s index wraps past the end of the bank
        start_run(S_DEPTH - 5);
        finish_run(S_DEPTH - 5);

        // Bank writes and a second start land while busy
        load_banks();
        start_run(7);
        wb_write(make_addr(REG_REGION, CTRL_OFS), 32'h1);
        for (int w = 0; w < 2; w++) begin
            rand_bits(32, rnd);
            wb_write(make_addr(VEC_REGION, w), rnd);
            wb_write(make_addr(S_REGION, w + 7), rnd);
        end
        finish_run(7);
        // Banks still hold the pre-run data
        readback_banks();

        for (int r = 0; r < 3; r++) begin
            load_banks();
            rand_bits(8, rnd);
            start_idx = rnd;
            start_run(start_idx);
            // Done must have cleared on start
            wb_read(make_addr(REG_REGION, STATUS_OFS), rd_data);
            check_value(rd_data, 32'h1, "STATUS during run");
            finish_run(start_idx);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("ERROR: watchdog expired after %0d cycles, errors so far: %0d",
                 WATCHDOG_CYCLES, errors);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== test/vec_add_assertions.sv ====
`timescale 1ns/1ps

module vec_add_assertions (
    input logic i_clk,
    input logic i_rst,
    input logic i_wb_cyc,
    input logic i_wb_stb,
    input logic i_wb_ack,
    input logic i_irq
);

    // Ack only answers a live request
    ack_with_request: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_ack |-> (i_wb_cyc && i_wb_stb))
        else $error("ack raised without cyc and stb");

    ack_single_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_ack |=> !i_wb_ack)
        else $error("ack held for two cycles");

    irq_single_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
        i_irq |=> !i_irq)
        else $error("irq held for two cycles");

endmodule

bind vec_add_top vec_add_assertions u_assertions (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_wb_cyc (i_wb_cyc),
    .i_wb_stb (i_wb_stb),
    .i_wb_ack (o_wb_ack),
    .i_irq    (o_irq)
);
